//--- Makefile
VERILATOR  ?= verilator
TOP        := etx_tb
FILELIST   := etx_top.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- design/etx_cfg.svh
`ifndef ETX_CFG_SVH
`define ETX_CFG_SVH

//##########################################################################
// Transmit link sizing
//##########################################################################

// Transaction queue
`define ETX_FIFO_DEPTH   4   // Entries between fabric and packet builder

// Serializer slot
// One parallel word goes out per slot, one byte per tx_lclk cycle,
// so the slot length is also the number of bytes in a parallel word
`define ETX_SLOT_CYCLES  8   // tx_lclk cycles per parallel word

`endif

//--- design/etx_fifo.sv
`timescale 1ns/10ps

`include "etx_cfg.svh"

module etx_fifo import etx_pkg::*;
(
   input  logic        tx_lclk,
   input  logic        arst_n,
   input  logic        push,         // One entry per strobe
   input  etx_packet_t push_packet,
   input  logic        pop,          // Removes the head
   output etx_packet_t head,         // Oldest entry, always visible
   output logic        empty,
   output logic        full
);

   localparam int PTR_W = $clog2(`ETX_FIFO_DEPTH);
   localparam int CNT_W = $clog2(`ETX_FIFO_DEPTH + 1);
   localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(`ETX_FIFO_DEPTH - 1);
   localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(`ETX_FIFO_DEPTH);

   etx_packet_t      mem [`ETX_FIFO_DEPTH];  // Entry storage
   logic [PTR_W-1:0] wr_ptr;                 // Next free slot
   logic [PTR_W-1:0] rd_ptr;                 // Oldest entry
   logic [CNT_W-1:0] count;                  // Entries held

   //##########################################################################
   // Storage
   //##########################################################################

   always_ff @(posedge tx_lclk)
   begin
      if (push)
         mem[wr_ptr] <= push_packet;         // Written at the tail
   end

   assign head = mem[rd_ptr];

   //##########################################################################
   // Pointers and occupancy
   //##########################################################################

   always_ff @(posedge tx_lclk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;  // Wrap at depth
         if (pop)
            rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;         // Both or neither
         endcase
      end
   end

   assign empty = (count == '0);
   assign full  = (count == CNT_FULL);       // Rises on the last storing edge

   // fabric must respect the full flag
   a_no_push_full: assert property (@(posedge tx_lclk) disable iff (!arst_n)
      push |-> !full)
      else $error("etx_fifo: push while full");

   // Builder only pops a queued entry
   a_no_pop_empty: assert property (@(posedge tx_lclk) disable iff (!arst_n)
      pop |-> !empty)
      else $error("etx_fifo: pop while empty");

endmodule

//--- design/etx_io.sv
`timescale 1ns/10ps

`include "etx_cfg.svh"

module etx_io
(
   input  logic       tx_lclk,
   input  logic       arst_n,
   input  logic       txi_wr_wait,   // Async write push-back pin
   input  logic       txi_rd_wait,   // Async read push-back pin
   output logic [7:0] txo_data,      // Byte lane
   output logic       txo_frame,
   etx_par_if.io      par
);

   localparam int PHASE_W = $clog2(`ETX_SLOT_CYCLES);
   localparam logic [PHASE_W-1:0] PHASE_LAST = PHASE_W'(`ETX_SLOT_CYCLES - 1);

   logic [PHASE_W-1:0] phase;        // Byte position within the slot
   logic [63:0]        shift_data;   // Outgoing word, top byte on the lane
   logic [7:0]         shift_frame;  // Matching frame bits
   logic [1:0]         wr_sync;      // Two-flop synchronizers
   logic [1:0]         rd_sync;

   //##########################################################################
   // Slot timer
   //##########################################################################

   always_ff @(posedge tx_lclk or negedge arst_n)
   begin
      if (!arst_n)
         phase <= '0;
      else if (par.slot_load)
         phase <= '0;                // Restart with the new word
      else
         phase <= phase + 1'b1;
   end

   assign par.slot_load = (phase == PHASE_LAST);   // Last byte of the slot

   //##########################################################################
   // Parallel to serial, MSB byte first
   //##########################################################################

   always_ff @(posedge tx_lclk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         shift_data  <= '0;
         shift_frame <= '0;
      end
      else if (par.slot_load)
      begin
         shift_data  <= par.data_par;            // Byte 7 shows next cycle
         shift_frame <= par.frame_par;
      end
      else
      begin
         shift_data  <= {shift_data[55:0], 8'h00};
         shift_frame <= {shift_frame[6:0], 1'b0};
      end
   end

   assign txo_data  = shift_data[63:56];
   assign txo_frame = shift_frame[7];

   //##########################################################################
   // Push-back synchronizers
   //##########################################################################

   always_ff @(posedge tx_lclk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wr_sync <= '0;
         rd_sync <= '0;
      end
      else
      begin
         wr_sync <= {wr_sync[0], txi_wr_wait};
         rd_sync <= {rd_sync[0], txi_rd_wait};
      end
   end

   assign par.wr_wait = wr_sync[1];  // Two cycles behind the pin
   assign par.rd_wait = rd_sync[1];

   // Slot cadence, checked once a full slot has passed since reset
   a_slot_period: assert property (@(posedge tx_lclk) disable iff (!arst_n)
      $past(par.slot_load, `ETX_SLOT_CYCLES) |-> par.slot_load)
      else $error("etx_io: slot_load missing after a slot");

   a_slot_gap: assert property (@(posedge tx_lclk) disable iff (!arst_n)
      par.slot_load && $past(arst_n, `ETX_SLOT_CYCLES)
         |-> $past(par.slot_load, `ETX_SLOT_CYCLES))
      else $error("etx_io: slot_load off its cadence");

endmodule

//--- design/etx_par_if.sv
`timescale 1ns/10ps

// Parallel word path between the packet builder and the serializer
interface etx_par_if;

   logic        slot_load;       // Pulse, one per slot
   logic        wr_wait;         // Write push-back, synchronized
   logic        rd_wait;         // Read push-back, synchronized
   logic [63:0] data_par;        // Byte 7 leaves first
   logic [7:0]  frame_par;       // Frame bit per byte, bit 7 first

   // Serializer side
   modport io
   (
      output slot_load,
      output wr_wait,
      output rd_wait,
      input  data_par,
      input  frame_par
   );

   // Packet builder side
   modport protocol
   (
      input  slot_load,
      input  wr_wait,
      input  rd_wait,
      output data_par,
      output frame_par
   );

endinterface

//--- design/etx_pkg.sv
package etx_pkg;

   //##########################################################################
   // Transaction and packet types
   //##########################################################################

   typedef enum logic [1:0]
   {
      OP_WRITE = 2'd0,           // Posted write
      OP_READ  = 2'd1            // Read request, response comes back elsewhere
   } etx_opcode_t;

   // Packet builder FSM
   typedef enum logic [1:0]
   {
      ST_IDLE,                   // Zero words, frame low
      ST_HEAD,                   // First word on the parallel bus
      ST_TAIL                    // Second word on the parallel bus
   } etx_state_t;

   // One fabric transaction, 98 bits
   typedef struct packed
   {
      etx_opcode_t opcode;       // Becomes the control byte
      logic [31:0] dstaddr;      // Packet bytes 1..4
      logic [31:0] data;         // Packet bytes 5..8
      logic [31:0] srcaddr;      // Packet bytes 9..12
   } etx_packet_t;

endpackage

//--- design/etx_protocol.sv
`timescale 1ns/10ps

module etx_protocol import etx_pkg::*;
(
   input  logic        tx_lclk,
   input  logic        arst_n,
   input  etx_packet_t head,         // Queue head
   input  logic        empty,
   output logic        pop,          // Head taken into a packet
   etx_par_if.protocol par
);

   etx_state_t  state;
   logic        blocked;             // Head held off by its wait line
   logic        start;               // A new packet may begin this slot
   logic [63:0] head_word;           // Packet bytes 0..7
   logic [63:0] tail_next;           // Packet bytes 8..15 of the head
   logic [63:0] tail_word;           // Bytes 8..15, held for ST_HEAD

   //##########################################################################
   // Push-back and packet words
   //##########################################################################

   always_comb
   begin
      if (head.opcode == OP_READ)
         blocked = par.rd_wait;      // Reads wait on read push-back
      else
         blocked = par.wr_wait;      // Writes on write push-back
   end

   // Second half of a packet never waits, so no start from ST_HEAD
   assign start = !empty && !blocked && (state != ST_HEAD);
   assign pop   = par.slot_load && start;

   // Control byte first, fields MSB first, zero pad at the end
   assign head_word = {6'b0, head.opcode, head.dstaddr, head.data[31:8]};
   assign tail_next = {head.data[7:0], head.srcaddr, 24'h0};

   always_ff @(posedge tx_lclk)
   begin
      if (pop)
         tail_word <= tail_next;     // Head leaves the queue now
   end

   //##########################################################################
   // Packet FSM, steps once per slot
   //##########################################################################

   always_ff @(posedge tx_lclk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state         <= ST_IDLE;
         par.data_par  <= '0;
         par.frame_par <= '0;
      end
      else if (par.slot_load)
      begin
         case (state)
            ST_HEAD:
            begin
               par.data_par  <= tail_word;      // Second word
               par.frame_par <= 8'hff;
               state         <= ST_TAIL;
            end
            ST_IDLE, ST_TAIL:
            begin
               if (start)
               begin
                  par.data_par  <= head_word;   // First word, back to back ok
                  par.frame_par <= 8'hff;
                  state         <= ST_HEAD;
               end
               else
               begin
                  par.data_par  <= '0;          // Idle slot
                  par.frame_par <= '0;
                  state         <= ST_IDLE;
               end
            end
            default:
            begin
               par.data_par  <= '0;
               par.frame_par <= '0;
               state         <= ST_IDLE;        // Unused encoding
            end
         endcase
      end
   end

   // Serializer captures the word on slot_load, so it must hold in between
   a_par_stable: assert property (@(posedge tx_lclk) disable iff (!arst_n)
      !$past(par.slot_load) |-> $stable(par.data_par) && $stable(par.frame_par))
      else $error("etx_protocol: parallel word changed between slots");

endmodule

//--- design/etx_top.sv
`timescale 1ns/10ps

module etx_top import etx_pkg::*;
(
   input  logic        tx_lclk,      // Link bit clock
   input  logic        arst_n,
   // Fabric side
   input  logic        tx_access,    // Push strobe
   input  etx_packet_t tx_packet,
   output logic        tx_full,
   // Link pins
   input  logic        txi_wr_wait,
   input  logic        txi_rd_wait,
   output logic [7:0]  txo_data,
   output logic        txo_frame
);

   etx_packet_t head;                // Queue to builder
   logic        empty;
   logic        pop;

   etx_par_if par ();                // Builder to serializer

   //##########################################################################
   // Transmit chain
   //##########################################################################

   etx_fifo u_fifo
   (
      .tx_lclk     (tx_lclk),
      .arst_n      (arst_n),
      .push        (tx_access),
      .push_packet (tx_packet),
      .pop         (pop),
      .head        (head),
      .empty       (empty),
      .full        (tx_full)
   );

   etx_protocol u_protocol
   (
      .tx_lclk (tx_lclk),
      .arst_n  (arst_n),
      .head    (head),
      .empty   (empty),
      .pop     (pop),
      .par     (par.protocol)
   );

   etx_io u_io
   (
      .tx_lclk     (tx_lclk),
      .arst_n      (arst_n),
      .txi_wr_wait (txi_wr_wait),
      .txi_rd_wait (txi_rd_wait),
      .txo_data    (txo_data),
      .txo_frame   (txo_frame),
      .par         (par.io)
   );

endmodule

//--- etx_top.f
+incdir+design
design/etx_pkg.sv
design/etx_par_if.sv
design/etx_fifo.sv
design/etx_protocol.sv
design/etx_io.sv
design/etx_top.sv
verification/etx_clkgen.sv
verification/etx_tb.sv

//--- verification/etx_clkgen.sv
`timescale 1ns/10ps

module etx_clkgen
(
   output logic clk,                 // Link bit clock
   output logic rst_n                // Async reset, active low
);

   localparam real HALF_PERIOD  = 2.0;   // 4 ns period
   localparam int  RESET_CYCLES = 5;

   initial
   begin
      clk = 1'b0;
      forever #(HALF_PERIOD) clk = ~clk;
   end

   initial
   begin
      rst_n = 1'b0;                  // Asserted from time zero
      repeat (RESET_CYCLES) @(posedge clk);
      #1 rst_n = 1'b1;               // Released off the edge
   end

endmodule

//--- verification/etx_tb.sv
`timescale 1ns/10ps

`include "etx_cfg.svh"

module etx_tb import etx_pkg::*; ();

   typedef logic [15:0][7:0] pkt_bytes_t;   // Index is the packet byte number

   logic        tx_lclk;
   logic        arst_n;
   logic        tx_access;
   etx_packet_t tx_packet;
   logic        tx_full;
   logic        txi_wr_wait;
   logic        txi_rd_wait;
   logic [7:0]  txo_data;
   logic        txo_frame;

   pkt_bytes_t  rx_q [$];            // Packets seen on the lane
   etx_packet_t exp_q [$];           // Packets pushed, oldest first
   pkt_bytes_t  cur_bytes;           // Packet being collected
   logic [3:0]  byte_idx = '0;
   int          frame_cycles = 0;    // Frame-high cycles so far

   etx_clkgen u_clkgen (.clk(tx_lclk), .rst_n(arst_n));

   etx_top DUT
   (
      .tx_lclk     (tx_lclk),
      .arst_n      (arst_n),
      .tx_access   (tx_access),
      .tx_packet   (tx_packet),
      .tx_full     (tx_full),
      .txi_wr_wait (txi_wr_wait),
      .txi_rd_wait (txi_rd_wait),
      .txo_data    (txo_data),
      .txo_frame   (txo_frame)
   );

   //##########################################################################
   // Lane monitor, sampled mid-cycle
   //##########################################################################

   always @(negedge tx_lclk)
   begin
      if (txo_frame)
      begin
         frame_cycles++;
         cur_bytes[byte_idx] = txo_data;
         if (byte_idx == 4'd15)
            rx_q.push_back(cur_bytes);   // Split every 16 bytes
         byte_idx = byte_idx + 4'd1;
      end
      else if (byte_idx != 4'd0)
      begin
         $display("ERROR at %0t: txo_frame fell after %0d bytes of a packet", $time, byte_idx);
         abort_run("frame cut short");
      end
   end

   //##########################################################################
   // Reporting and compares
   //##########################################################################

   task automatic abort_run(string why);
      $display("Test failures found");
      $fatal(1, "%s", why);
   endtask

   task automatic check_packet(etx_packet_t expected, etx_packet_t got, string msg);
      if (got !== expected)
      begin
         $display("CHECK FAILED at %0t: %s: expected %h, got %h", $time, msg, expected, got);
         abort_run("packet mismatch");
      end
   endtask

   task automatic check_bytes(pkt_bytes_t expected, pkt_bytes_t got, string msg);
      if (got !== expected)
      begin
         $display("CHECK FAILED at %0t: %s: expected %h, got %h", $time, msg, expected, got);
         abort_run("byte mismatch");
      end
   endtask

   task automatic check_bit(logic expected, logic got, string msg);
      if (got !== expected)
      begin
         $display("CHECK FAILED at %0t: %s: expected %b, got %b", $time, msg, expected, got);
         abort_run("level mismatch");
      end
   endtask

   // Lane image of a packet, built from the byte order rules
   function automatic pkt_bytes_t expected_bytes(etx_packet_t p);
      pkt_bytes_t b;
      b     = '0;                    // Bytes 13..15 stay zero
      b[0]  = {6'b0, p.opcode};      // Control byte
      b[1]  = p.dstaddr[31:24];
      b[2]  = p.dstaddr[23:16];
      b[3]  = p.dstaddr[15:8];
      b[4]  = p.dstaddr[7:0];
      b[5]  = p.data[31:24];
      b[6]  = p.data[23:16];
      b[7]  = p.data[15:8];
      b[8]  = p.data[7:0];
      b[9]  = p.srcaddr[31:24];
      b[10] = p.srcaddr[23:16];
      b[11] = p.srcaddr[15:8];
      b[12] = p.srcaddr[7:0];
      return b;
   endfunction

   function automatic etx_packet_t rebuild_packet(pkt_bytes_t b);
      etx_packet_t p;
      p.opcode  = etx_opcode_t'(b[0][1:0]);
      p.dstaddr = {b[1], b[2], b[3], b[4]};
      p.data    = {b[5], b[6], b[7], b[8]};
      p.srcaddr = {b[9], b[10], b[11], b[12]};
      return p;
   endfunction

   function automatic etx_packet_t make_packet(etx_opcode_t op, logic [31:0] dst,
                                               logic [31:0] dat, logic [31:0] src);
      etx_packet_t p;
      p.opcode  = op;
      p.dstaddr = dst;
      p.data    = dat;
      p.srcaddr = src;
      return p;
   endfunction

   function automatic etx_packet_t random_packet();
      etx_packet_t p;
      p.opcode  = ($urandom() & 32'd1) ? OP_READ : OP_WRITE;
      p.dstaddr = $urandom();
      p.data    = $urandom();
      p.srcaddr = $urandom();
      return p;
   endfunction

   //##########################################################################
   // Stimulus and bounded waits
   //##########################################################################

   task automatic next_cycle();
      @(posedge tx_lclk);
      #1;                            // Drive point
   endtask

   task automatic wait_not_full(int limit);
      int n;
      n = 0;
      while (tx_full)
      begin
         next_cycle();
         n++;
         if (n > limit)
         begin
            $display("ERROR at %0t: tx_full never dropped", $time);
            abort_run("timeout on tx_full");
         end
      end
   endtask

   task automatic wait_for_packets(int count, int limit);
      int n;
      n = 0;
      while (rx_q.size() < count)
      begin
         next_cycle();
         n++;
         if (n > limit)
         begin
            $display("ERROR at %0t: only %0d of %0d packets came out", $time,
                     rx_q.size(), count);
            abort_run("timeout on packets");
         end
      end
   endtask

   task automatic send_packet(etx_packet_t p);
      wait_not_full(200);
      tx_access = 1'b1;
      tx_packet = p;
      exp_q.push_back(p);
      next_cycle();
      tx_access = 1'b0;
   endtask

   task automatic drain_and_compare(string name);
      pkt_bytes_t  got;
      etx_packet_t exp;
      check_bit(1'b1, rx_q.size() == exp_q.size(), {name, ": packet count"});
      while (exp_q.size() > 0)
      begin
         got = rx_q.pop_front();
         exp = exp_q.pop_front();
         check_packet(exp, rebuild_packet(got), {name, ": fields"});
         check_bytes(expected_bytes(exp), got, {name, ": lane bytes"});
      end
   endtask

   //##########################################################################
   // Directed tests
   //##########################################################################

   task automatic test_reset_state();
      repeat (32)
      begin
         @(negedge tx_lclk);
         check_bit(1'b0, txo_frame, "reset: txo_frame");
         check_bit(1'b0, tx_full, "reset: tx_full");
         check_bit(1'b1, txo_data == 8'h00, "reset: txo_data zero");
      end
   endtask

   task automatic test_single_write();
      int start;
      start = frame_cycles;
      send_packet(make_packet(OP_WRITE, 32'h1122_3344, 32'h5566_7788, 32'h99aa_bbcc));
      wait_for_packets(1, 100);
      repeat (32) next_cycle();      // Nothing more may follow
      check_bit(1'b1, frame_cycles - start == 16, "single write: 16 frame cycles");
      drain_and_compare("single write");
   endtask

   task automatic test_read_packet();
      pkt_bytes_t got;
      send_packet(make_packet(OP_READ, 32'h0a0b_0c0d, 32'h0000_0000, 32'hdead_beef));
      wait_for_packets(1, 100);
      got = rx_q[0];
      check_bit(1'b1, got[0] == 8'h01, "read: control byte");
      check_bit(1'b1, {got[9], got[10], got[11], got[12]} == 32'hdead_beef,
                "read: srcaddr bytes");
      drain_and_compare("read");
   endtask

   task automatic test_streaming();
      for (int i = 0; i < 20; i++)
         send_packet(random_packet());   // Throttled by tx_full
      wait_for_packets(20, 1000);
      drain_and_compare("streaming");
   endtask

   // Pin held high keeps the packet off the lane, dropping it lets it out
   task automatic blocked_then_sent(etx_opcode_t op, logic wr, logic rd, string name);
      int start;
      txi_wr_wait = wr;
      txi_rd_wait = rd;
      repeat (`ETX_SLOT_CYCLES) next_cycle();
      start = frame_cycles;
      send_packet(make_packet(op, $urandom(), $urandom(), $urandom()));
      repeat (64) next_cycle();
      check_bit(1'b1, frame_cycles == start, {name, ": no frame while blocked"});
      txi_wr_wait = 1'b0;
      txi_rd_wait = 1'b0;
      wait_for_packets(1, 100);
      drain_and_compare(name);
   endtask

   task automatic test_push_back();
      blocked_then_sent(OP_WRITE, 1'b1, 1'b0, "write under wr_wait");
      blocked_then_sent(OP_READ, 1'b0, 1'b1, "read under rd_wait");
      txi_wr_wait = 1'b1;            // Must not hold a read
      repeat (`ETX_SLOT_CYCLES) next_cycle();
      send_packet(make_packet(OP_READ, 32'h0102_0304, 32'h0, 32'h0506_0708));
      wait_for_packets(1, 48);       // Pop, head word, 16 bytes
      txi_wr_wait = 1'b0;
      drain_and_compare("read under wr_wait");
   endtask

   task automatic test_full_flag();
      etx_packet_t p;
      txi_wr_wait = 1'b1;
      repeat (`ETX_SLOT_CYCLES) next_cycle();
      for (int i = 0; i < `ETX_FIFO_DEPTH; i++)
      begin
         check_bit(1'b0, tx_full, "full: tx_full before push");
         p        = random_packet();
         p.opcode = OP_WRITE;
         send_packet(p);
      end
      check_bit(1'b1, tx_full, "full: tx_full after last push");
      txi_wr_wait = 1'b0;
      wait_for_packets(`ETX_FIFO_DEPTH, 400);
      drain_and_compare("full flag");
      check_bit(1'b0, tx_full, "full: tx_full after drain");
   endtask

   initial
   begin
      tx_access   = 1'b0;
      tx_packet   = '0;
      txi_wr_wait = 1'b0;
      txi_rd_wait = 1'b0;
      void'($urandom(68));           // Fixed seed
      test_reset_state();
      next_cycle();
      test_single_write();
      test_read_packet();
      test_streaming();
      test_push_back();
      test_full_flag();
      $display("All tests passed!");
      $finish;
   end

endmodule
